// File: logic/tp84_pkg.sv
package tp84_pkg;

	// ========================================================================
	// Keyboard
	// ========================================================================

	// PS/2 set 2 make codes of the keys in use
	typedef enum logic [7:0] {
		KEY_START1  = 8'h16,
		KEY_START2  = 8'h1E,
		KEY_COIN1   = 8'h2E,
		KEY_COIN2   = 8'h36,
		KEY_SERVICE = 8'h46,
		KEY_PAUSE   = 8'h4D,
		KEY_UP      = 8'h75,
		KEY_DOWN    = 8'h72,
		KEY_LEFT    = 8'h6B,
		KEY_RIGHT   = 8'h74,
		KEY_SHOT    = 8'h14,
		KEY_MISSILE = 8'h11
	} key_code_e;

	// Held key levels, active high
	typedef struct packed {
		logic start1;
		logic start2;
		logic coin1;
		logic coin2;
		logic service;
		logic pause;
		logic up;
		logic down;
		logic left;
		logic right;
		logic shot;
		logic missile;
	} kbd_buttons_t;

	// USB joystick word bit positions
	localparam int JOY_RIGHT   = 0;
	localparam int JOY_LEFT    = 1;
	localparam int JOY_DOWN    = 2;
	localparam int JOY_UP      = 3;
	localparam int JOY_SHOT    = 4;
	localparam int JOY_MISSILE = 5;
	localparam int JOY_START1  = 6;
	localparam int JOY_COIN1   = 7;
	localparam int JOY_START2  = 8;
	localparam int JOY_PAUSE   = 9;

	// Core inputs, all active low
	typedef struct packed {
		logic [1:0] coin;
		logic [1:0] start;
		logic [3:0] p1_joy;   // right, left, down, up
		logic [3:0] p2_joy;
		logic [2:0] p1_btn;   // spare, missile, shot
		logic [1:0] p2_btn;
		logic       service;
	} arcade_inputs_t;

	// ========================================================================
	// Download stream and PLL reconfiguration
	// ========================================================================

	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} ioctl_t;

	localparam logic [7:0] DIP_INDEX    = 8'd254;
	localparam logic [7:0] ROMSET_INDEX = 8'd1;
	localparam int         DIP_BANKS    = 2;

	// Reconfiguration port write
	typedef struct packed {
		logic        write;
		logic [5:0]  address;
		logic [31:0] data;
	} pll_cfg_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_MODE,
		SEQ_GAP2,
		SEQ_GAP3,
		SEQ_GAP4,
		SEQ_COUNTER,
		SEQ_GAP6,
		SEQ_START
	} seq_state_e;

	localparam logic [5:0]  PLL_ADDR_MODE    = 6'd0;
	localparam logic [5:0]  PLL_ADDR_COUNTER = 6'd7;
	localparam logic [5:0]  PLL_ADDR_START   = 6'd2;
	// Fractional counter words, ~1% underclock for 60 Hz vsync
	localparam logic [31:0] PLL_C_NATIVE     = 32'd3639383488;
	localparam logic [31:0] PLL_C_UNDERCLOCK = 32'd3262113561;

	// ========================================================================
	// Video
	// ========================================================================

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb4_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb8_t;

	// Measured output of the weighted resistor DAC
	localparam logic [7:0] COLOR_LEVELS [16] = '{
		8'd0,   8'd14,  8'd31,  8'd45,
		8'd66,  8'd80,  8'd96,  8'd111,
		8'd144, 8'd158, 8'd175, 8'd190,
		8'd210, 8'd225, 8'd241, 8'd255
	};

endpackage

// File: logic/ps2_key_decoder.sv
`timescale 1ns/100ps

module ps2_key_decoder (
	input  logic                   CLK_49M,
	input  logic                   rst,
	input  logic [10:0]            ps2_key,
	output tp84_pkg::kbd_buttons_t buttons
);

	// Event fields
	logic       toggle_q;
	logic       key_event;
	logic       pressed;
	logic [7:0] code;

	// Host flips bit 10 once per key event
	assign key_event = ps2_key[10] != toggle_q;
	assign pressed   = ps2_key[9];
	assign code      = ps2_key[7:0];

	// ========================================================================
	// Held levels
	// ========================================================================

	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			toggle_q <= 1'b0;
			buttons  <= '0;
		end else begin
			toggle_q <= ps2_key[10];
			if (key_event) begin
				// Make sets, break clears
				case (code)
					tp84_pkg::KEY_START1:  buttons.start1  <= pressed;
					tp84_pkg::KEY_START2:  buttons.start2  <= pressed;
					tp84_pkg::KEY_COIN1:   buttons.coin1   <= pressed;
					tp84_pkg::KEY_COIN2:   buttons.coin2   <= pressed;
					tp84_pkg::KEY_SERVICE: buttons.service <= pressed;
					tp84_pkg::KEY_PAUSE:   buttons.pause   <= pressed;
					// Cursor keys
					tp84_pkg::KEY_UP:      buttons.up      <= pressed;
					tp84_pkg::KEY_DOWN:    buttons.down    <= pressed;
					tp84_pkg::KEY_LEFT:    buttons.left    <= pressed;
					tp84_pkg::KEY_RIGHT:   buttons.right   <= pressed;
					// Ctrl and Alt
					tp84_pkg::KEY_SHOT:    buttons.shot    <= pressed;
					tp84_pkg::KEY_MISSILE: buttons.missile <= pressed;
					// Other keys ignored
					default: ;
				endcase
			end
		end
	end

endmodule

// File: logic/player_input_merge.sv
`timescale 1ns/100ps

module player_input_merge (
	input  logic                     CLK_49M,
	input  logic                     rst,
	input  tp84_pkg::kbd_buttons_t   buttons,
	input  logic [15:0]              joystick_0,
	input  logic [15:0]              joystick_1,
	output tp84_pkg::arcade_inputs_t arcade
);

	// Active-high merged levels
	tp84_pkg::arcade_inputs_t merged;
	// Either stick, for the shared controls
	logic [15:0]              joy_any;

	assign joy_any = joystick_0 | joystick_1;

	// Directions in core order, right down to up
	function automatic logic [3:0] joy_dirs(input logic [15:0] joy,
	                                        input tp84_pkg::kbd_buttons_t kb);
		joy_dirs = {kb.right | joy[tp84_pkg::JOY_RIGHT],
		            kb.left  | joy[tp84_pkg::JOY_LEFT],
		            kb.down  | joy[tp84_pkg::JOY_DOWN],
		            kb.up    | joy[tp84_pkg::JOY_UP]};
	endfunction

	// Missile above shot
	function automatic logic [1:0] joy_fire(input logic [15:0] joy,
	                                        input tp84_pkg::kbd_buttons_t kb);
		joy_fire = {kb.missile | joy[tp84_pkg::JOY_MISSILE],
		            kb.shot    | joy[tp84_pkg::JOY_SHOT]};
	endfunction

	always_comb begin
		// Coin 2 keyboard only
		merged.coin    = {buttons.coin2, buttons.coin1 | joy_any[tp84_pkg::JOY_COIN1]};
		merged.start   = {buttons.start2 | joy_any[tp84_pkg::JOY_START2],
		                  buttons.start1 | joy_any[tp84_pkg::JOY_START1]};
		merged.p1_joy  = joy_dirs(joystick_0, buttons);
		merged.p2_joy  = joy_dirs(joystick_1, buttons);
		// Spare button never pressed
		merged.p1_btn  = {1'b0, joy_fire(joystick_0, buttons)};
		merged.p2_btn  = joy_fire(joystick_1, buttons);
		merged.service = buttons.service;
	end

	// Registered, inverted for the core
	always_ff @(posedge CLK_49M) begin
		if (rst)
			arcade <= '1;
		else
			arcade <= ~merged;
	end

endmodule

// File: logic/dip_switch_loader.sv
`timescale 1ns/100ps

module dip_switch_loader (
	input  logic             CLK_49M,
	input  logic             rst,
	input  tp84_pkg::ioctl_t ioctl,
	output logic [15:0]      dip_sw,
	output logic             rom_set3
);

	// Bank 1 above bank 0
	logic [tp84_pkg::DIP_BANKS-1:0][7:0] bank;

	// ========================================================================
	// Download capture
	// ========================================================================

	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			bank     <= '0;
			rom_set3 <= 1'b0;
		end else if (ioctl.wr) begin
			// DIP settings file
			if (ioctl.index == tp84_pkg::DIP_INDEX) begin
				for (int i = 0; i < tp84_pkg::DIP_BANKS; i++) begin
					if (ioctl.addr == 25'(i))
						bank[i] <= ioctl.data;
				end
			end
			// First byte of the MRA flags the set 3 ROMs
			if (ioctl.index == tp84_pkg::ROMSET_INDEX && ioctl.addr == '0)
				rom_set3 <= ioctl.data[0];
		end
	end

	// Switches read active low
	assign dip_sw = ~bank;

	// Banks only move on a download write
	a_bank_needs_wr: assert property (
		@(posedge CLK_49M) disable iff (rst)
		!ioctl.wr |=> $stable(bank)
	);

endmodule

// File: logic/pll_underclock_seq.sv
`timescale 1ns/100ps

module pll_underclock_seq (
	input  logic               CLK_49M,
	input  logic               rst,
	input  logic               underclock,
	input  logic               cfg_waitrequest,
	output tp84_pkg::pll_cfg_t cfg
);

	// Option synchronizer and applied setting
	logic                 uc_meta;
	logic                 uc_sync;
	logic                 uc_applied;
	tp84_pkg::seq_state_e state;
	tp84_pkg::seq_state_e state_next;

	// Configuration write fields
	logic                 cfg_write;
	logic [5:0]           cfg_address;
	logic [31:0]          cfg_data;

	// Steps advance in encoding order, START wraps to IDLE
	assign state_next = tp84_pkg::seq_state_e'(state + 3'd1);

	// ========================================================================
	// Step control
	// ========================================================================

	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			uc_meta    <= 1'b0;
			uc_sync    <= 1'b0;
			uc_applied <= 1'b0;
			state      <= tp84_pkg::SEQ_IDLE;
			cfg_write  <= 1'b0;
		end else begin
			uc_meta   <= underclock;
			uc_sync   <= uc_meta;
			cfg_write <= 1'b0;
			// Everything holds under back-pressure
			if (!cfg_waitrequest) begin
				case (state)
					tp84_pkg::SEQ_IDLE: begin
						// Settled new option
						if (uc_sync == uc_meta && uc_sync != uc_applied) begin
							uc_applied <= uc_sync;
							state      <= tp84_pkg::SEQ_MODE;
						end
					end
					tp84_pkg::SEQ_MODE,
					tp84_pkg::SEQ_COUNTER,
					tp84_pkg::SEQ_START: begin
						cfg_write <= 1'b1;
						state     <= state_next;
					end
					// Gap steps
					default: state <= state_next;
				endcase
			end
		end
	end

	// ========================================================================
	// Write payload
	// ========================================================================

	always_ff @(posedge CLK_49M) begin
		if (!cfg_waitrequest) begin
			case (state)
				tp84_pkg::SEQ_MODE: begin
					cfg_address <= tp84_pkg::PLL_ADDR_MODE;
					cfg_data    <= '0;
				end
				tp84_pkg::SEQ_COUNTER: begin
					cfg_address <= tp84_pkg::PLL_ADDR_COUNTER;
					cfg_data    <= uc_applied ? tp84_pkg::PLL_C_UNDERCLOCK
					                          : tp84_pkg::PLL_C_NATIVE;
				end
				tp84_pkg::SEQ_START: begin
					cfg_address <= tp84_pkg::PLL_ADDR_START;
					cfg_data    <= '0;
				end
				default: ;
			endcase
		end
	end

	assign cfg = '{write: cfg_write, address: cfg_address, data: cfg_data};

	// Gap steps keep writes apart
	a_single_pulse: assert property (
		@(posedge CLK_49M) disable iff (rst)
		cfg_write |=> !cfg_write
	);

	a_hold_on_wait: assert property (
		@(posedge CLK_49M) disable iff (rst)
		cfg_waitrequest |=> $stable(state)
	);

endmodule

// File: logic/color_dac_lut.sv
`timescale 1ns/100ps

module color_dac_lut (
	input  logic            CLK_49M,
	input  logic            rst,
	input  tp84_pkg::rgb4_t rgb_in,
	output tp84_pkg::rgb8_t rgb_out
);

	// ========================================================================
	// Resistor DAC levels
	// ========================================================================

	// Same table for all three guns
	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			rgb_out <= '0;
		end else begin
			rgb_out.r <= tp84_pkg::COLOR_LEVELS[rgb_in.r];
			rgb_out.g <= tp84_pkg::COLOR_LEVELS[rgb_in.g];
			rgb_out.b <= tp84_pkg::COLOR_LEVELS[rgb_in.b];
		end
	end

endmodule

// File: logic/tp84_io_top.sv
`timescale 1ns/100ps

module tp84_io_top (
	input  logic                     CLK_49M,
	input  logic                     rst,
	input  logic [10:0]              ps2_key,
	input  logic [15:0]              joystick_0,
	input  logic [15:0]              joystick_1,
	input  tp84_pkg::ioctl_t         ioctl,
	input  logic                     underclock,
	input  logic                     cfg_waitrequest,
	input  tp84_pkg::rgb4_t          rgb_in,
	output tp84_pkg::arcade_inputs_t arcade,
	output logic [15:0]              dip_sw,
	output logic                     rom_set3,
	output tp84_pkg::pll_cfg_t       cfg,
	output tp84_pkg::rgb8_t          rgb_out
);

	// Keyboard levels into the merge
	tp84_pkg::kbd_buttons_t buttons;

	// ========================================================================
	// Player controls
	// ========================================================================

	ps2_key_decoder u_kbd (
		.CLK_49M (CLK_49M),
		.rst     (rst),
		.ps2_key (ps2_key),
		.buttons (buttons)
	);

	player_input_merge u_merge (
		.CLK_49M    (CLK_49M),
		.rst        (rst),
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.arcade     (arcade)
	);

	// ========================================================================
	// Configuration
	// ========================================================================

	dip_switch_loader u_dip (
		.CLK_49M  (CLK_49M),
		.rst      (rst),
		.ioctl    (ioctl),
		.dip_sw   (dip_sw),
		.rom_set3 (rom_set3)
	);

	pll_underclock_seq u_pll_seq (
		.CLK_49M         (CLK_49M),
		.rst             (rst),
		.underclock      (underclock),
		.cfg_waitrequest (cfg_waitrequest),
		.cfg             (cfg)
	);

	// Video out
	color_dac_lut u_dac (
		.CLK_49M (CLK_49M),
		.rst     (rst),
		.rgb_in  (rgb_in),
		.rgb_out (rgb_out)
	);

endmodule

// File: dv/tp84_io_tb.sv
`timescale 1ns/100ps

module tp84_io_tb;

	// Cycles watched per underclock case
	localparam int UC_WINDOW = 200;

	logic                     CLK_49M;
	logic                     rst;
	logic [10:0]              ps2_key;
	logic [15:0]              joystick_0;
	logic [15:0]              joystick_1;
	tp84_pkg::ioctl_t         ioctl;
	logic                     underclock;
	logic                     cfg_waitrequest;
	tp84_pkg::rgb4_t          rgb_in;
	tp84_pkg::arcade_inputs_t arcade;
	logic [15:0]              dip_sw;
	logic                     rom_set3;
	tp84_pkg::pll_cfg_t       cfg;
	tp84_pkg::rgb8_t          rgb_out;

	// Run totals
	int checks;
	int errors;
	int cases_run;

	// Port names match the top level
	tp84_io_top dut0 (.*);

	initial begin
		CLK_49M = 1'b0;
		forever #50 CLK_49M = ~CLK_49M;
	end

	task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("CHECK FAILED %0s expected %h actual %h", name, expected, actual);
		end
	endtask

	// ========================================================================
	// Case drivers
	// ========================================================================

	task automatic send_key_event(input logic [8*24-1:0] name, input logic [7:0] code,
			input logic pressed, input logic [31:0] expected);
		@(posedge CLK_49M);
		// New event flips bit 10
		ps2_key <= {~ps2_key[10], pressed, 1'b0, code};
		// Decoder, then merge register
		repeat (2) @(posedge CLK_49M);
		@(negedge CLK_49M);
		check_value(name, expected, 32'(arcade));
	endtask

	task automatic drive_joysticks(input logic [8*24-1:0] name, input logic [15:0] joy0,
			input logic [15:0] joy1, input logic [31:0] expected);
		@(posedge CLK_49M);
		joystick_0 <= joy0;
		joystick_1 <= joy1;
		@(posedge CLK_49M);
		@(negedge CLK_49M);
		check_value(name, expected, 32'(arcade));
	endtask

	task automatic send_download_write(input logic [8*24-1:0] name, input logic [7:0] index,
			input logic [24:0] addr, input logic [7:0] data, input logic [31:0] expected);
		@(posedge CLK_49M);
		ioctl <= '{wr: 1'b1, index: index, addr: addr, data: data};
		// One-cycle strobe
		@(posedge CLK_49M);
		ioctl.wr <= 1'b0;
		@(negedge CLK_49M);
		check_value(name, expected, 32'({rom_set3, dip_sw}));
	endtask

	task automatic apply_underclock(input logic [8*24-1:0] name, input logic level,
			input int count, input logic [31:0] counter_data);
		logic [31:0] exp_addr [3];
		logic [31:0] exp_data [3];
		int          seen;
		logic        prev_write;
		logic        prev_wait;
		// Mode, counter, start
		exp_addr = '{32'd0, 32'd7, 32'd2};
		exp_data = '{32'd0, counter_data, 32'd0};
		seen = 0;
		prev_write = 1'b0;
		@(posedge CLK_49M);
		underclock <= level;
		// Level the DUT samples on the next edge
		prev_wait = cfg_waitrequest;
		for (int cyc = 0; cyc < UC_WINDOW; cyc++) begin
			@(posedge CLK_49M);
			// Stall about one cycle in four
			cfg_waitrequest <= ($urandom % 4) == 0;
			@(negedge CLK_49M);
			if (cfg.write) begin
				if (prev_write) begin
					errors++;
					$display("Configuration write pulse in %0s lasted two cycles", name);
				end
				// Issuing edge saw a stall
				if (prev_wait) begin
					errors++;
					$display("Configuration write in %0s was issued during waitrequest",
						name);
				end
				if (seen < 3) begin
					check_value(name, exp_addr[seen], 32'(cfg.address));
					check_value(name, exp_data[seen], cfg.data);
				end
				seen++;
			end
			prev_write = cfg.write;
			prev_wait = cfg_waitrequest;
		end
		@(posedge CLK_49M);
		cfg_waitrequest <= 1'b0;
		if (seen < count) begin
			errors++;
			$display("Timed out in %0s waiting for PLL writes, saw %0d", name, seen);
		end else begin
			// Extra writes show up here
			check_value(name, 32'(count), 32'(seen));
		end
	endtask

	task automatic drive_colour(input logic [8*24-1:0] name, input logic [11:0] colour,
			input logic [31:0] expected);
		@(posedge CLK_49M);
		rgb_in <= colour;
		@(posedge CLK_49M);
		@(negedge CLK_49M);
		check_value(name, expected, 32'(rgb_out));
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		string           line;
		logic [7:0]      kind;
		logic [8*24-1:0] name;
		logic [31:0]     a;
		logic [31:0]     b;
		logic [31:0]     c;
		logic [31:0]     expected;
		int              fd;
		int              fields;
		checks = 0;
		errors = 0;
		cases_run = 0;
		void'($urandom(32'hd5ba_0a84));
		// All inputs idle
		rst = 1'b1;
		ps2_key = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		ioctl = '0;
		underclock = 1'b0;
		cfg_waitrequest = 1'b0;
		rgb_in = '0;
		repeat (16) @(posedge CLK_49M);
		rst <= 1'b0;
		@(negedge CLK_49M);
		// Reset state
		check_value("reset_arcade", 32'h3ffff, 32'(arcade));
		check_value("reset_dip_sw", 32'hffff, 32'(dip_sw));
		check_value("reset_cfg_write", 32'd0, 32'(cfg.write));
		check_value("reset_rgb_out", 32'd0, 32'(rgb_out));
		fd = $fopen("dv/tp84_io_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the case file dv/tp84_io_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Skip blanks and comment lines
				if (line.len() < 2 || line[0] == "#")
					continue;
				fields = $sscanf(line, "%s %s %h %h %h %h", kind, name, a, b, c, expected);
				if (fields != 6) begin
					errors++;
					$display("Malformed case line: %s", line);
					continue;
				end
				cases_run++;
				case (kind)
					"K": send_key_event(name, a[7:0], b[0], expected);
					"J": drive_joysticks(name, a[15:0], b[15:0], expected);
					"D": send_download_write(name, a[7:0], b[24:0], c[7:0], expected);
					"U": apply_underclock(name, a[0], int'(b), expected);
					"C": drive_colour(name, a[11:0], expected);
					default: begin
						errors++;
						$display("Unknown case kind in line: %s", line);
					end
				endcase
			end
			$fclose(fd);
		end
		$display("Cases: %0d, checks: %0d, errors: %0d", cases_run, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: tp84_io.f
logic/tp84_pkg.sv
logic/ps2_key_decoder.sv
logic/player_input_merge.sv
logic/dip_switch_loader.sv
logic/pll_underclock_seq.sv
logic/color_dac_lut.sv
logic/tp84_io_top.sv
dv/tp84_io_tb.sv

// File: Makefile
# Verilator build and run of the tp84_io testbench

compile:
	verilator --binary --timing --assert -j 0 --top-module tp84_io_tb -Mdir obj_dir -f tp84_io.f

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/Vtp84_io_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

.PHONY: compile run clean

// File: dv/tp84_io_cases.txt
# kind name a b c expected, all hex; K code pressed 0 arcade; J joy0 joy1 0 arcade
# D index addr data {rom_set3,dip_sw}; U level writes 0 counter_data; C rgb_in 0 0 rgb_out
K key_up_press 75 1 0 3fbbf
K key_up_release 75 0 0 3ffff
K key_shot_press 14 1 0 3fff5
K key_shot_release 14 0 0 3ffff
K key_coin2_press 36 1 0 1ffff
K key_coin2_release 36 0 0 3ffff
K key_unknown 5a 1 0 3ffff
J joy0_right 0001 0000 0 3dfff
J joy1_fire 0000 0030 0 3fff9
J joy1_start_coin 0000 01c0 0 23fff
J joy0_all ffff 0000 0 203e7
J joy_clear 0000 0000 0 3ffff
D dip_bank0 fe 0 a5 0ff5a
D dip_bank1 fe 1 3c 0c35a
D dip_addr2 fe 2 00 0c35a
D other_index 03 0 ff 0c35a
D romset_set 01 0 01 1c35a
D romset_clear 01 0 fe 0c35a
U uc_on 1 3 0 c26fe719
U uc_hold 1 0 0 0
U uc_off 0 3 0 d8ec95c0
C col_zero 000 0 0 000000
C col_mix 1af 0 0 0eafff
C col_mid 837 0 0 902d6f
C col_steps c5e 0 0 d250f1
